//--- source/icache_pkg.sv
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 32;
    localparam int LINE_W   = 128;
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = 22;
    localparam int NWAY     = 2;
    localparam int NSET     = 1 << INDEX_W;

    //////////////////////////////////////////////////////////////////////
    // Address word
    //////////////////////////////////////////////////////////////////////

    // Normal lookup view
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_t;

    // Index invalidate view, way number sits in the lowest tag bit
    typedef struct packed {
        logic [TAG_W-2:0]    unused;
        logic                way;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } idx_addr_t;

    typedef union packed {
        fetch_addr_t fetch;
        idx_addr_t   idx;
    } icache_addr_u;

    //////////////////////////////////////////////////////////////////////
    // Cache operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CACOP_NONE    = 2'd0,
        CACOP_IDX_INV = 2'd1,
        CACOP_HIT_INV = 2'd2
    } cacop_e;

endpackage

//--- source/icache_lookup_if.sv
interface icache_lookup_if;

    import icache_pkg::*;

    // Stage-1 request
    logic         valid;
    icache_addr_u addr;
    cacop_e       op;

    // Array contents for the stage-1 set, one entry per way
    logic [NWAY-1:0][TAG_W-1:0]  tag_rd;
    logic [NWAY-1:0]             vld_rd;
    logic [NWAY-1:0][LINE_W-1:0] data_rd;

    // Request side
    modport src (
        output valid,
        output addr,
        output op
    );

    // Consumer side of the request, the array fills in the read fields
    modport dst (
        input  valid,
        input  addr,
        input  op,
        output tag_rd,
        output vld_rd,
        output data_rd
    );

endinterface

//--- source/icache_addr_decode.sv
module icache_addr_decode (
    input  logic                      clk,
    input  logic                      rst_n,

    // Fetch request
    input  logic                      req_i,
    input  icache_pkg::icache_addr_u  addr_i,

    // Cache operation
    input  logic                      cacop_en_i,
    input  icache_pkg::cacop_e        cacop_mode_i,
    input  icache_pkg::icache_addr_u  cacop_addr_i,

    input  logic                      stall_i,
    output logic                      take_o,

    icache_lookup_if.src              lk,
    output logic [icache_pkg::INDEX_W-1:0] rd_index_o
);

    import icache_pkg::*;

    logic         s1_valid;
    icache_addr_u s1_addr;
    cacop_e       s1_op;

    // Stage 1 frees up whenever refill control is not holding it
    assign take_o = req_i && !stall_i;

    //////////////////////////////////////////////////////////////////////
    // Array read index
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cacop_en_i) begin
            rd_index_o = cacop_addr_i.fetch.index;
        end else if (stall_i) begin
            // Replay of the held miss
            rd_index_o = s1_addr.fetch.index;
        end else begin
            rd_index_o = addr_i.fetch.index;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage-1 request register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_addr  <= '0;
            s1_op    <= CACOP_NONE;
        end else if (cacop_en_i) begin
            s1_valid <= 1'b1;
            s1_addr  <= cacop_addr_i;
            s1_op    <= cacop_mode_i;
        end else if (!stall_i) begin
            // A finished cache op drops out here since req_i is low
            s1_valid <= req_i;
            s1_op    <= CACOP_NONE;
            if (req_i) begin
                s1_addr <= addr_i;
            end
        end
    end

    assign lk.valid = s1_valid;
    assign lk.addr  = s1_addr;
    assign lk.op    = s1_op;

endmodule

//--- source/icache_way_array.sv
module icache_way_array (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [icache_pkg::INDEX_W-1:0]  rd_index_i,
    icache_lookup_if.dst                    lk,

    // Single write port
    input  logic                            we_i,
    input  logic                            wr_way_i,
    input  logic [icache_pkg::INDEX_W-1:0]  wr_index_i,
    input  logic [icache_pkg::TAG_W-1:0]    wr_tag_i,
    input  logic                            wr_valid_i,
    input  logic [icache_pkg::LINE_W-1:0]   wr_data_i
);

    import icache_pkg::*;

    logic [TAG_W-1:0]  tag_q  [NWAY][NSET];
    logic [LINE_W-1:0] data_q [NWAY][NSET];
    logic [NWAY-1:0][NSET-1:0] vld_q;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (we_i) begin
            vld_q[wr_way_i][wr_index_i] <= wr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[wr_way_i][wr_index_i]  <= wr_tag_i;
            data_q[wr_way_i][wr_index_i] <= wr_data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Synchronous read
    //////////////////////////////////////////////////////////////////////

    // Same-cycle write to the read set shows up one read later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk.vld_rd <= '0;
        end else begin
            for (int w = 0; w < NWAY; w++) begin
                lk.vld_rd[w] <= vld_q[w][rd_index_i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NWAY; w++) begin
            lk.tag_rd[w]  <= tag_q[w][rd_index_i];
            lk.data_rd[w] <= data_q[w][rd_index_i];
        end
    end

endmodule

//--- source/icache_hit_select.sv
module icache_hit_select (
    icache_lookup_if.dst                   lk,

    output logic                           hit_o,
    output logic                           hit_way_o,

    output logic                           rvalid_o,
    output logic [icache_pkg::LINE_W-1:0]  rdata_o
);

    import icache_pkg::*;

    logic [NWAY-1:0] way_hit;

    // Tag compare per way
    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = lk.vld_rd[w] && (lk.tag_rd[w] == lk.addr.fetch.tag);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Way select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = 1'b0;
        rdata_o   = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (way_hit[w]) begin
                hit_o     = 1'b1;
                hit_way_o = w[0];
                rdata_o   = lk.data_rd[w];
            end
        end
    end

    // Only a plain fetch returns data
    assign rvalid_o = lk.valid && (lk.op == CACOP_NONE) && hit_o;

endmodule

//--- source/icache_refill_ctrl.sv
module icache_refill_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,

    icache_lookup_if.dst                    lk,
    input  logic                            take_i,
    input  logic                            hit_i,
    input  logic                            hit_way_i,

    output logic                            stall_o,
    output logic                            cacop_done_o,

    // Memory port
    output logic                            mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0]   mem_addr_o,
    input  logic                            mem_rdy_i,
    input  logic                            mem_rvalid_i,
    input  logic [icache_pkg::LINE_W-1:0]   mem_data_i,

    // Array write port
    output logic                            we_o,
    output logic                            wr_way_o,
    output logic [icache_pkg::INDEX_W-1:0]  wr_index_o,
    output logic [icache_pkg::TAG_W-1:0]    wr_tag_o,
    output logic                            wr_valid_o,
    output logic [icache_pkg::LINE_W-1:0]   wr_data_o
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        REPLAY
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic [2:0] lfsr_q;
    logic       fetch_miss;
    logic       op_valid;

    assign op_valid   = lk.valid && (lk.op != CACOP_NONE);
    assign fetch_miss = (state_q == IDLE) && lk.valid && (lk.op == CACOP_NONE) && !hit_i;

    // Hold stage 1 from the miss cycle through the replay
    assign stall_o = fetch_miss || (state_q != IDLE);

    //////////////////////////////////////////////////////////////////////
    // Refill FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_miss) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (mem_rdy_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = REPLAY;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Victim LFSR x^3 + x^2 + 1 steps on each accepted request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= 3'b001;
        end else if (take_i) begin
            lfsr_q <= {lfsr_q[1:0], lfsr_q[2] ^ lfsr_q[1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory request
    //////////////////////////////////////////////////////////////////////

    assign mem_req_o  = (state_q == REQ);
    assign mem_addr_o = {lk.addr.fetch.tag, lk.addr.fetch.index, {OFFSET_W{1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // Array writes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        we_o       = 1'b0;
        wr_way_o   = lfsr_q[0];
        wr_valid_o = 1'b0;
        wr_index_o = lk.addr.fetch.index;
        case (state_q)
            WAIT: begin
                if (mem_rvalid_i) begin
                    we_o       = 1'b1;
                    wr_valid_o = 1'b1;
                end
            end
            IDLE: begin
                if (op_valid && lk.op == CACOP_IDX_INV) begin
                    we_o     = 1'b1;
                    wr_way_o = lk.addr.idx.way;
                end else if (op_valid && hit_i) begin
                    // Hit invalidate clears only the hitting way
                    we_o     = 1'b1;
                    wr_way_o = hit_way_i;
                end
            end
            default: begin
            end
        endcase
    end

    assign wr_tag_o  = lk.addr.fetch.tag;
    assign wr_data_o = mem_data_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cacop_done_o <= 1'b0;
        end else begin
            cacop_done_o <= (state_q == IDLE) && op_valid;
        end
    end

endmodule

//--- source/icache_top.sv
module icache_top (
    input  logic                            clk,
    input  logic                            rst_n,

    // Fetch port
    input  logic                            req_i,
    input  logic [icache_pkg::ADDR_W-1:0]   addr_i,
    output logic                            rvalid_o,
    output logic [icache_pkg::LINE_W-1:0]   rdata_o,

    // Cache operations
    input  logic                            cacop_en_i,
    input  logic [1:0]                      cacop_mode_i,
    input  logic [icache_pkg::ADDR_W-1:0]   cacop_addr_i,
    output logic                            cacop_done_o,

    // Memory port
    output logic                            mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0]   mem_addr_o,
    input  logic                            mem_rdy_i,
    input  logic                            mem_rvalid_i,
    input  logic [icache_pkg::LINE_W-1:0]   mem_data_i
);

    import icache_pkg::*;

    cacop_e             cacop_mode;
    logic               stall;
    logic               take;
    logic [INDEX_W-1:0] rd_index;
    logic               hit;
    logic               hit_way;

    logic               we;
    logic               wr_way;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   wr_tag;
    logic               wr_valid;
    logic [LINE_W-1:0]  wr_data;

    assign cacop_mode = cacop_e'(cacop_mode_i);

    icache_lookup_if u_lk ();

    icache_addr_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .cacop_en_i   (cacop_en_i),
        .cacop_mode_i (cacop_mode),
        .cacop_addr_i (cacop_addr_i),
        .stall_i      (stall),
        .take_o       (take),
        .lk           (u_lk.src),
        .rd_index_o   (rd_index)
    );

    icache_way_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_i (rd_index),
        .lk         (u_lk.dst),
        .we_i       (we),
        .wr_way_i   (wr_way),
        .wr_index_i (wr_index),
        .wr_tag_i   (wr_tag),
        .wr_valid_i (wr_valid),
        .wr_data_i  (wr_data)
    );

    icache_hit_select u_hit (
        .lk        (u_lk.dst),
        .hit_o     (hit),
        .hit_way_o (hit_way),
        .rvalid_o  (rvalid_o),
        .rdata_o   (rdata_o)
    );

    icache_refill_ctrl u_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .lk           (u_lk.dst),
        .take_i       (take),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .stall_o      (stall),
        .cacop_done_o (cacop_done_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdy_i    (mem_rdy_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_data_i   (mem_data_i),
        .we_o         (we),
        .wr_way_o     (wr_way),
        .wr_index_o   (wr_index),
        .wr_tag_o     (wr_tag),
        .wr_valid_o   (wr_valid),
        .wr_data_o    (wr_data)
    );

endmodule

//--- bench/icache_checker.sv
module icache_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rvalid_o,
    input  logic [icache_pkg::LINE_W-1:0]  rdata_o,
    input  logic                           cacop_en_i,
    input  logic                           cacop_done_o,
    input  logic                           mem_req_o,
    input  logic [icache_pkg::ADDR_W-1:0]  mem_addr_o,
    input  logic                           mem_rdy_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Memory request held with a stable address until taken
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_o && !mem_rdy_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("mem_req_o dropped or mem_addr_o changed before mem_rdy_i");

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(rvalid_o && mem_req_o))
        else $error("rvalid_o and mem_req_o high together");

    // Cache op completes two cycles after the strobe
    op_done_late: assert property (@(posedge clk) disable iff (!rst_n)
        cacop_en_i |-> ##2 cacop_done_o)
        else $error("cacop_done_o missing two cycles after cacop_en_i");

    op_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
        cacop_done_o |-> $past(cacop_en_i, 2))
        else $error("cacop_done_o without cacop_en_i two cycles earlier");

    no_x: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({rvalid_o, rdata_o, cacop_done_o, mem_req_o, mem_addr_o}))
        else $error("Unknown value on a cache output");

endmodule

//--- bench/icache_tb.sv
module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int TIMEOUT  = 200;
    localparam int POOL_SET = 8;
    localparam int POOL_TAG = 4;

    logic               clk;
    logic               rst_n;
    logic               req_i;
    logic [ADDR_W-1:0]  addr_i;
    logic               rvalid_o;
    logic [LINE_W-1:0]  rdata_o;
    logic               cacop_en_i;
    logic [1:0]         cacop_mode_i;
    logic [ADDR_W-1:0]  cacop_addr_i;
    logic               cacop_done_o;
    logic               mem_req_o;
    logic [ADDR_W-1:0]  mem_addr_o;
    logic               mem_rdy_i;
    logic               mem_rvalid_i;
    logic [LINE_W-1:0]  mem_data_i;

    logic [31:0] stim_state;
    logic [31:0] mem_state;

    // Reference model per pool set
    logic [POOL_TAG-1:0] may_res  [POOL_SET];
    logic [POOL_TAG-1:0] sure_res [POOL_SET];
    logic [1:0]          inv_ways [POOL_SET];

    icache_top u_dut (.*);

    bind icache_top icache_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .cacop_en_i   (cacop_en_i),
        .cacop_done_o (cacop_done_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdy_i    (mem_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned draw(input int unsigned n);
        stim_state = lcg_next(stim_state);
        return int'(stim_state[30:16]) % n;
    endfunction

    function automatic int draw_latency();
        mem_state = lcg_next(mem_state);
        return 1 + int'(mem_state[20:16]) % 6;
    endfunction

    // Four words of line address xor a per-word constant
    function automatic logic [LINE_W-1:0] mem_line(input logic [ADDR_W-1:0] la);
        return {la ^ 32'hc3a5_0f96, la ^ 32'h5a1e_77d2, la ^ 32'h9b04_e13c, la ^ 32'h2d6f_b845};
    endfunction

    function automatic logic [INDEX_W-1:0] pool_index(input int s);
        return INDEX_W'(s * 8 + 3);
    endfunction

    function automatic logic [ADDR_W-1:0] pool_addr(input int s, input int t,
                                                    input logic [OFFSET_W-1:0] off);
        logic [TAG_W-1:0] tag;
        tag = TAG_W'(32'h0002_b1c0 + t * 32'h0000_0d35);
        return {tag, pool_index(s), off};
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [LINE_W-1:0] exp,
                         input logic [LINE_W-1:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory responder
    //////////////////////////////////////////////////////////////////////

    initial begin : memory_responder
        logic [ADDR_W-1:0] line_addr;
        int                lat;
        forever begin
            @(posedge clk);
            #2;
            if (rst_n && mem_req_o) begin
                lat = draw_latency();
                repeat (lat - 1) begin
                    @(posedge clk);
                    #2;
                end
                line_addr = mem_addr_o;
                mem_rdy_i = 1'b1;
                @(posedge clk);
                #2;
                mem_rdy_i = 1'b0;
                lat       = draw_latency();
                repeat (lat - 1) begin
                    @(posedge clk);
                    #2;
                end
                mem_rvalid_i = 1'b1;
                mem_data_i   = mem_line(line_addr);
                @(posedge clk);
                #2;
                mem_rvalid_i = 1'b0;
                mem_data_i   = '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request tasks
    //////////////////////////////////////////////////////////////////////

    task automatic fetch(input int s, input int t, input string name);
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] line_addr;
        logic              prev_req;
        int                cycles;
        int                reqs;
        addr      = pool_addr(s, t, OFFSET_W'(draw(16)));
        line_addr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        req_i     = 1'b1;
        addr_i    = addr;
        prev_req  = 1'b0;
        cycles    = 0;
        reqs      = 0;
        do begin
            @(posedge clk);
            #2;
            cycles++;
            if (mem_req_o && !prev_req) begin
                reqs++;
                check({name, " mem_addr_o"}, LINE_W'(line_addr), LINE_W'(mem_addr_o));
            end
            prev_req = mem_req_o;
            if (!rvalid_o && cycles >= TIMEOUT) begin
                $display("Timeout: %s got no rvalid_o for address %h", name, addr);
                abort_run();
            end
        end while (!rvalid_o);
        check({name, " rdata_o"}, mem_line(line_addr), rdata_o);
        if (reqs > 1) begin
            $display("%s raised more than one memory request for one miss", name);
            abort_run();
        end
        if (!may_res[s][t]) begin
            check({name, " miss requests"}, LINE_W'(1), LINE_W'(reqs));
        end else if (sure_res[s][t]) begin
            check({name, " hit requests"}, LINE_W'(0), LINE_W'(reqs));
            check({name, " hit latency"}, LINE_W'(1), LINE_W'(cycles));
        end
        if (reqs != 0) begin
            // Victim way unknown so the other line may be gone
            sure_res[s]    = '0;
            sure_res[s][t] = 1'b1;
            may_res[s][t]  = 1'b1;
            inv_ways[s]    = '0;
        end
        req_i = 1'b0;
        @(posedge clk);
        #2;
    endtask

    // Both lines resident and returned on consecutive cycles
    task automatic fetch_pair(input int sa, input int ta, input int sb, input int tb,
                              input string name);
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        a      = pool_addr(sa, ta, 4'h0);
        b      = pool_addr(sb, tb, 4'h8);
        req_i  = 1'b1;
        addr_i = a;
        @(posedge clk);
        #2;
        check({name, " first rvalid_o"}, LINE_W'(1), LINE_W'(rvalid_o));
        check({name, " first rdata_o"}, mem_line({a[ADDR_W-1:OFFSET_W], 4'h0}), rdata_o);
        addr_i = b;
        @(posedge clk);
        #2;
        check({name, " second rvalid_o"}, LINE_W'(1), LINE_W'(rvalid_o));
        check({name, " second rdata_o"}, mem_line({b[ADDR_W-1:OFFSET_W], 4'h0}), rdata_o);
        req_i = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic cache_op(input cacop_e mode, input logic [ADDR_W-1:0] addr,
                            input string name);
        int cycles;
        cacop_en_i   = 1'b1;
        cacop_mode_i = mode;
        cacop_addr_i = addr;
        cycles       = 0;
        do begin
            @(posedge clk);
            #2;
            cacop_en_i = 1'b0;
            cycles++;
            if (!cacop_done_o && cycles >= TIMEOUT) begin
                $display("Timeout: %s never raised cacop_done_o", name);
                abort_run();
            end
        end while (!cacop_done_o);
        check({name, " done latency"}, LINE_W'(2), LINE_W'(cycles));
        @(posedge clk);
        #2;
    endtask

    task automatic hit_inv(input int s, input int t, input string name);
        cache_op(CACOP_HIT_INV, pool_addr(s, t, 4'h0), name);
        may_res[s][t]  = 1'b0;
        sure_res[s][t] = 1'b0;
    endtask

    task automatic idx_inv(input int s, input int w, input string name);
        icache_addr_u target;
        target           = '0;
        target.idx.way   = w[0];
        target.idx.index = pool_index(s);
        cache_op(CACOP_IDX_INV, target, name);
        sure_res[s]    = '0;
        inv_ways[s][w] = 1'b1;
        if (inv_ways[s] == 2'b11) begin
            may_res[s] = '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int unsigned pick;
        int          s;
        int          t;
        rst_n        = 1'b0;
        req_i        = 1'b0;
        addr_i       = '0;
        cacop_en_i   = 1'b0;
        cacop_mode_i = CACOP_NONE;
        cacop_addr_i = '0;
        mem_rdy_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_data_i   = '0;
        stim_state   = 32'd46424;
        mem_state    = 32'd46424;
        for (int i = 0; i < POOL_SET; i++) begin
            may_res[i]  = '0;
            sure_res[i] = '0;
            inv_ways[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        fetch(0, 0, "refill miss");
        fetch(0, 0, "refill rehit");
        hit_inv(0, 0, "hit_inv");
        fetch(0, 0, "hit_inv refetch");

        fetch(1, 0, "idx_inv fill0");
        fetch(1, 1, "idx_inv fill1");
        idx_inv(1, 0, "idx_inv way0");
        idx_inv(1, 1, "idx_inv way1");
        fetch(1, 0, "idx_inv refetch0");
        fetch(1, 1, "idx_inv refetch1");

        fetch(2, 0, "pair fill a");
        fetch(3, 1, "pair fill b");
        fetch_pair(2, 0, 3, 1, "back_to_back");

        // Random mix over the address pool
        for (int i = 0; i < 400; i++) begin
            pick = draw(20);
            s    = int'(draw(POOL_SET));
            t    = int'(draw(POOL_TAG));
            if (pick < 14) begin
                fetch(s, t, "random fetch");
            end else if (pick < 17) begin
                hit_inv(s, t, "random hit_inv");
            end else begin
                idx_inv(s, int'(draw(2)), "random idx_inv");
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- tb.f
source/icache_pkg.sv
source/icache_lookup_if.sv
source/icache_addr_decode.sv
source/icache_way_array.sv
source/icache_hit_select.sv
source/icache_refill_ctrl.sv
source/icache_top.sv
bench/icache_checker.sv
bench/icache_tb.sv

//--- run.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module icache_tb -f tb.f || exit 1
./obj_dir/Vicache_tb > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || exit 1
exit 0
